// ==== Makefile ====
TOP = dataCacheTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timescale 1ns/1ns -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== rtl/cacheController.sv ====
`default_nettype none
`timescale 1ns/1ns

module cacheController import cachePkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  reqValid,
  input  cpuReq                 req,
  input  logic                  flushReq,
  input  logic                  busReady,
  input  logic [31:0]           busRdata,
  input  logic                  hit,
  input  logic                  hitWay,
  input  wayFill                victim,
  input  logic [31:0]           readWord,
  output logic                  respValid,
  output logic [31:0]           rdata,
  output logic                  flushDone,
  output logic                  busValid,
  output busReq                 bus,
  output logic [IndexBits-1:0]  index,
  output logic [TagBits-1:0]    lookupTag,
  output logic                  accessWay,
  output logic                  touch,
  output logic                  install,
  output logic                  setDirty,
  output logic                  clearDirty,
  output logic [OffsetBits-1:0] wordSel,
  output logic                  writeEn,
  output logic [3:0]            wordMask,
  output logic [31:0]           writeData
);

  localparam logic [OffsetBits-1:0] LastWord = OffsetBits'(WordsPerLine - 1);

  cacheState state;
  cacheState nextState;

  // Word position within the line being moved over the bus
  logic [OffsetBits-1:0] beat;
  // Walk position during flush, set in the upper bits and way in bit 0
  logic [IndexBits:0]    flushCount;
  logic                  flushActive;
  logic                  fillWay;
  logic [31:0]           rdataReg;

  logic beatTaken;
  logic lastBeat;
  logic hitAccept;
  logic missAccept;
  logic flushLast;
  logic enterTransfer;

  assign beatTaken  = busValid && busReady;
  assign lastBeat   = beatTaken && (beat == LastWord);
  assign hitAccept  = (state == Ready) && !flushReq && reqValid && hit;
  assign missAccept = (state == Ready) && !flushReq && reqValid && !hit;
  assign flushLast  = (flushCount == '1);

  // Beat counter restarts whenever a new line transfer begins
  assign enterTransfer = (nextState != state) &&
                         ((nextState == WriteBack) || (nextState == MemRead));

  always_comb begin
    nextState = state;
    case (state)
      Ready: begin
        if (flushReq) begin
          nextState = Flush;
        end else if (reqValid) begin
          if (hit) begin
            nextState = Respond;
          end else if (victim.dirty) begin
            nextState = WriteBack;
          end else begin
            nextState = MemRead;
          end
        end
      end
      Respond: nextState = Ready;
      WriteBack: begin
        if (lastBeat) begin
          nextState = flushActive ? Flush : MemRead;
        end
      end
      // Refilled line is looked up again in Ready and hits there
      MemRead: begin
        if (lastBeat) begin
          nextState = Ready;
        end
      end
      Flush: begin
        if (victim.dirty) begin
          nextState = WriteBack;
        end else if (flushLast) begin
          nextState = FlushDone;
        end
      end
      FlushDone: nextState = Ready;
      default:   nextState = Ready;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= Ready;
      beat        <= '0;
      flushCount  <= '0;
      flushActive <= 1'b0;
      fillWay     <= 1'b0;
    end else begin
      state <= nextState;

      if (enterTransfer) begin
        beat <= '0;
      end else if (beatTaken) begin
        beat <= beat + 1'b1;
      end

      if ((state == Ready) && flushReq) begin
        flushCount  <= '0;
        flushActive <= 1'b1;
      end else if (state == FlushDone) begin
        flushActive <= 1'b0;
      end else if ((state == Flush) && !victim.dirty && !flushLast) begin
        // A dirty entry is revisited after its writeback, then found clean
        flushCount <= flushCount + 1'b1;
      end

      if (missAccept) begin
        fillWay <= victim.way;
      end
    end
  end

  // Read data captured on the hit cycle
  always_ff @(posedge clk) begin
    if (hitAccept) begin
      rdataReg <= readWord;
    end
  end

  assign respValid = (state == Respond);
  assign rdata     = rdataReg;
  assign flushDone = (state == FlushDone);

  assign index     = flushActive ? flushCount[IndexBits:1]
                                 : req.addr[ByteBits+OffsetBits +: IndexBits];
  assign lookupTag = req.addr[31 -: TagBits];

  // In Ready hitWay already names the replacement way on a miss
  assign accessWay = ((state == Ready) || (state == Respond)) ? hitWay
                   : (flushActive ? flushCount[0] : fillWay);

  assign touch      = hitAccept;
  assign setDirty   = hitAccept && req.write;
  assign install    = (state == MemRead) && lastBeat;
  assign clearDirty = (state == WriteBack) && flushActive && lastBeat;

  always_comb begin
    if ((state == WriteBack) || (state == MemRead)) begin
      wordSel = beat;
    end else begin
      wordSel = req.addr[ByteBits +: OffsetBits];
    end
  end

  // Refill words overwrite the whole word, hits merge by byte lane
  assign writeEn   = (hitAccept && req.write) || ((state == MemRead) && beatTaken);
  assign wordMask  = (state == MemRead) ? 4'hf : req.byteMask;
  assign writeData = (state == MemRead) ? busRdata : req.wdata;

  assign busValid = (state == WriteBack) || (state == MemRead);

  always_comb begin
    bus.write = (state == WriteBack);
    if (state == WriteBack) begin
      bus.addr  = {victim.tag, index, beat, {ByteBits{1'b0}}};
      bus.wdata = readWord;
    end else begin
      bus.addr  = {lookupTag, index, beat, {ByteBits{1'b0}}};
      bus.wdata = '0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cachePkg.sv ====
`default_nettype none

package cachePkg;

  // Cache geometry
  localparam int NumSets      = 16;
  localparam int NumWays      = 2;
  localparam int WordsPerLine = 4;

  // Address fields, low to high: byte, word, set, tag
  localparam int ByteBits   = 2;
  localparam int OffsetBits = 2;
  localparam int IndexBits  = 4;
  localparam int TagBits    = 32 - IndexBits - OffsetBits - ByteBits;

  // Load/store request, held by the CPU until respValid
  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [3:0]  byteMask;
    logic [31:0] wdata;
  } cpuReq;

  // One word beat on the memory bus
  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } busReq;

  // Replacement choice plus state of the way being accessed
  typedef struct packed {
    logic               way;
    logic               dirty;
    logic [TagBits-1:0] tag;
  } wayFill;

  typedef enum logic [2:0] {
    Ready,
    Respond,
    WriteBack,
    MemRead,
    Flush,
    FlushDone
  } cacheState;

endpackage

`default_nettype wire

// ==== rtl/dataCache.sv ====
`default_nettype none
`timescale 1ns/1ns

module dataCache import cachePkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        reqValid,
  input  cpuReq       req,
  output logic        respValid,
  output logic [31:0] rdata,
  input  logic        flushReq,
  output logic        flushDone,
  output logic        busValid,
  output busReq       bus,
  input  logic        busReady,
  input  logic [31:0] busRdata
);

  // Controller to tag store
  logic [IndexBits-1:0]  index;
  logic [TagBits-1:0]    lookupTag;
  logic                  accessWay;
  logic                  touch;
  logic                  install;
  logic                  setDirty;
  logic                  clearDirty;
  logic                  hit;
  logic                  hitWay;
  wayFill                victim;

  // Controller to line store
  logic [OffsetBits-1:0] wordSel;
  logic                  writeEn;
  logic [3:0]            wordMask;
  logic [31:0]           writeData;
  logic [31:0]           readWord;

  cacheController ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .req        (req),
    .flushReq   (flushReq),
    .busReady   (busReady),
    .busRdata   (busRdata),
    .hit        (hit),
    .hitWay     (hitWay),
    .victim     (victim),
    .readWord   (readWord),
    .respValid  (respValid),
    .rdata      (rdata),
    .flushDone  (flushDone),
    .busValid   (busValid),
    .bus        (bus),
    .index      (index),
    .lookupTag  (lookupTag),
    .accessWay  (accessWay),
    .touch      (touch),
    .install    (install),
    .setDirty   (setDirty),
    .clearDirty (clearDirty),
    .wordSel    (wordSel),
    .writeEn    (writeEn),
    .wordMask   (wordMask),
    .writeData  (writeData)
  );

  tagStore tags_i (
    .clk        (clk),
    .reset      (reset),
    .index      (index),
    .lookupTag  (lookupTag),
    .accessWay  (accessWay),
    .touch      (touch),
    .install    (install),
    .setDirty   (setDirty),
    .clearDirty (clearDirty),
    .hit        (hit),
    .hitWay     (hitWay),
    .victim     (victim)
  );

  lineStore data_i (
    .clk       (clk),
    .index     (index),
    .accessWay (accessWay),
    .wordSel   (wordSel),
    .writeEn   (writeEn),
    .wordMask  (wordMask),
    .writeData (writeData),
    .readWord  (readWord)
  );

endmodule

`default_nettype wire

// ==== rtl/lineStore.sv ====
`default_nettype none
`timescale 1ns/1ns

module lineStore import cachePkg::*; (
  input  logic                  clk,
  input  logic [IndexBits-1:0]  index,
  input  logic                  accessWay,
  input  logic [OffsetBits-1:0] wordSel,
  input  logic                  writeEn,
  input  logic [3:0]            wordMask,
  input  logic [31:0]           writeData,
  output logic [31:0]           readWord
);

  // Set, way, word
  logic [31:0] lines [NumSets][NumWays][WordsPerLine];

  // Combinational read so a writeback beat sees its word at once
  assign readWord = lines[index][accessWay][wordSel];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      for (int b = 0; b < 4; b++) begin
        if (wordMask[b]) begin
          lines[index][accessWay][wordSel][8*b +: 8] <= writeData[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tagStore.sv ====
`default_nettype none
`timescale 1ns/1ns

module tagStore import cachePkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [IndexBits-1:0] index,
  input  logic [TagBits-1:0]   lookupTag,
  input  logic                 accessWay,
  input  logic                 touch,
  input  logic                 install,
  input  logic                 setDirty,
  input  logic                 clearDirty,
  output logic                 hit,
  output logic                 hitWay,
  output wayFill               victim
);

  logic [TagBits-1:0] tags [NumSets][NumWays];
  logic [NumWays-1:0] valid [NumSets];
  logic [NumWays-1:0] dirty [NumSets];
  // Per set, the way that was used least recently
  logic [NumSets-1:0] lru;

  logic [NumWays-1:0] wayHit;
  logic               choice;

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayHit[w] = valid[index][w] && (tags[index][w] == lookupTag);
    end
  end

  assign hit = |wayHit;

  // Empty ways are filled before anything is evicted
  always_comb begin
    if (!valid[index][0]) begin
      choice = 1'b0;
    end else if (!valid[index][1]) begin
      choice = 1'b1;
    end else begin
      choice = lru[index];
    end
  end

  // On a miss the reported way is the one to replace
  assign hitWay = hit ? wayHit[1] : choice;

  // State of the accessed way, used for writeback address and flush
  always_comb begin
    victim.way   = choice;
    victim.dirty = valid[index][accessWay] && dirty[index][accessWay];
    victim.tag   = tags[index][accessWay];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < NumSets; s++) begin
        valid[s] <= '0;
        dirty[s] <= '0;
      end
      lru <= '0;
    end else begin
      if (touch) begin
        lru[index] <= ~accessWay;
      end
      if (install) begin
        valid[index][accessWay] <= 1'b1;
        dirty[index][accessWay] <= 1'b0;
      end else if (setDirty) begin
        dirty[index][accessWay] <= 1'b1;
      end else if (clearDirty) begin
        dirty[index][accessWay] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (install) begin
      tags[index][accessWay] <= lookupTag;
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/cachePkg.sv
rtl/lineStore.sv
rtl/tagStore.sv
rtl/cacheController.sv
rtl/dataCache.sv
tb/busMemory.sv
tb/dataCacheTb.sv

// ==== tb/busMemory.sv ====
`default_nettype none
`timescale 1ns/1ns

module busMemory import cachePkg::*; #(
  parameter logic [31:0] FillKey = 32'h0,
  parameter logic [31:0] Seed    = 32'h1
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        busValid,
  input  busReq       bus,
  output logic        busReady,
  output logic [31:0] busRdata,
  output int          readBeats,
  output int          writeBeats
);

  localparam int Words = 4096;

  logic [31:0] mem [Words];
  logic [31:0] rngState;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Every word starts as its own byte address scrambled by the key
  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[i] = {i[29:0], 2'b00} ^ FillKey;
    end
  end

  // Read data is valid whenever ready is high
  assign busRdata = mem[bus.addr[13:2]];

  // Ready drops on roughly one cycle in three
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      rngState   <= Seed;
      busReady   <= 1'b0;
      readBeats  <= 0;
      writeBeats <= 0;
    end else begin
      rngState <= xorshift(rngState);
      busReady <= (xorshift(rngState) % 3) != 0;
      if (busValid && busReady) begin
        if (bus.write) begin
          writeBeats <= writeBeats + 1;
        end else begin
          readBeats <= readBeats + 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (busValid && busReady && bus.write) begin
      mem[bus.addr[13:2]] <= bus.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== tb/dataCacheTb.sv ====
`default_nettype none
`timescale 1ns/1ns

module dataCacheTb import cachePkg::*; ();

  localparam logic [31:0] FillKey        = 32'h3c5a_96e1;
  localparam logic [31:0] Seed           = 32'hf66badc5;
  localparam int          MemWords       = 4096;
  localparam int          CyclesPerEntry = 64;

  typedef enum logic [1:0] {
    OpRead,
    OpWrite,
    OpFlush
  } opKind;

  // One row of the operation table
  typedef struct packed {
    opKind       kind;
    logic [31:0] addr;
    logic [3:0]  mask;
    logic [31:0] wdata;
    int          expRd;
    int          expWr;
  } testEntry;

  logic        clk;
  logic        reset;
  logic        reqValid;
  cpuReq       req;
  logic        respValid;
  logic [31:0] rdata;
  logic        flushReq;
  logic        flushDone;
  logic        busValid;
  busReq       bus;
  logic        busReady;
  logic [31:0] busRdata;
  int          readBeats;
  int          writeBeats;

  testEntry    ops [$];
  logic [31:0] shadow [MemWords];
  int          errors;
  int          passedTests;
  int          cycles;
  int          cycleLimit;

  dataCache dut_i (
    .clk       (clk),
    .reset     (reset),
    .reqValid  (reqValid),
    .req       (req),
    .respValid (respValid),
    .rdata     (rdata),
    .flushReq  (flushReq),
    .flushDone (flushDone),
    .busValid  (busValid),
    .bus       (bus),
    .busReady  (busReady),
    .busRdata  (busRdata)
  );

  busMemory #(
    .FillKey (FillKey),
    .Seed    (Seed)
  ) mem_i (
    .clk        (clk),
    .reset      (reset),
    .busValid   (busValid),
    .bus        (bus),
    .busReady   (busReady),
    .busRdata   (busRdata),
    .readBeats  (readBeats),
    .writeBeats (writeBeats)
  );

  always #4 clk = ~clk;

  // Watchdog over the whole run
  always @(posedge clk) begin : watchdog
    cacheState stuckState;
    cycles = cycles + 1;
    if ((cycleLimit > 0) && (cycles > cycleLimit)) begin
      stuckState = dut_i.ctrl_i.state;
      $display("Timeout after %0d cycles, controller still in state %s",
               cycles, stuckState.name());
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] fillWord(input int idx);
    return {idx[29:0], 2'b00} ^ FillKey;
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] mask);
    logic [31:0] merged;
    merged = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic addEntry(input opKind kind, input logic [31:0] addr, input logic [3:0] mask,
                          input logic [31:0] wdata, input int expRd, input int expWr);
    testEntry e;
    e.kind  = kind;
    e.addr  = addr;
    e.mask  = mask;
    e.wdata = wdata;
    e.expRd = expRd;
    e.expWr = expWr;
    ops.push_back(e);
  endtask

  // Address fields: tag 31..8, set 7..4, word 3..2
  task automatic buildOps();
    // Cold miss in set 1, then a hit in the same line
    addEntry(OpRead,  32'h0000_0110, 4'h0, 32'h0000_0000, 4, 0);
    addEntry(OpRead,  32'h0000_011c, 4'h0, 32'h0000_0000, 0, 0);
    // Byte-masked stores on a resident line in set 2
    addEntry(OpRead,  32'h0000_0520, 4'h0, 32'h0000_0000, 4, 0);
    addEntry(OpWrite, 32'h0000_0524, 4'h3, 32'h1234_5678, 0, 0);
    addEntry(OpWrite, 32'h0000_0524, 4'h8, 32'hab00_0000, 0, 0);
    addEntry(OpRead,  32'h0000_0524, 4'h0, 32'h0000_0000, 0, 0);
    addEntry(OpWrite, 32'h0000_0528, 4'hf, 32'hcafe_f00d, 0, 0);
    addEntry(OpRead,  32'h0000_0528, 4'h0, 32'h0000_0000, 0, 0);
    // LRU in set 1 with tags 1, 2 and 3
    addEntry(OpRead,  32'h0000_0210, 4'h0, 32'h0000_0000, 4, 0);
    addEntry(OpRead,  32'h0000_0114, 4'h0, 32'h0000_0000, 0, 0);
    addEntry(OpRead,  32'h0000_0310, 4'h0, 32'h0000_0000, 4, 0);
    addEntry(OpRead,  32'h0000_0110, 4'h0, 32'h0000_0000, 0, 0);
    addEntry(OpRead,  32'h0000_0218, 4'h0, 32'h0000_0000, 4, 0);
    // Dirty evictions in set 2
    addEntry(OpWrite, 32'h0000_0620, 4'hf, 32'h0bad_f00d, 4, 0);
    addEntry(OpRead,  32'h0000_0720, 4'h0, 32'h0000_0000, 4, 4);
    addEntry(OpRead,  32'h0000_0524, 4'h0, 32'h0000_0000, 4, 4);
    addEntry(OpRead,  32'h0000_0620, 4'h0, 32'h0000_0000, 4, 0);
    // Three dirty lines, then two flushes
    addEntry(OpWrite, 32'h0000_0114, 4'h6, 32'h00aa_bb00, 0, 0);
    addEntry(OpWrite, 32'h0000_052c, 4'hf, 32'h1122_3344, 0, 0);
    addEntry(OpWrite, 32'h0000_0830, 4'hf, 32'h5566_7788, 4, 0);
    addEntry(OpFlush, 32'h0000_0000, 4'h0, 32'h0000_0000, 0, 12);
    addEntry(OpFlush, 32'h0000_0000, 4'h0, 32'h0000_0000, 0, 0);
    addEntry(OpRead,  32'h0000_0114, 4'h0, 32'h0000_0000, 0, 0);
    addEntry(OpRead,  32'h0000_0830, 4'h0, 32'h0000_0000, 0, 0);
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compareBacking();
    for (int i = 0; i < MemWords; i++) begin
      checkWord($sformatf("backing[0x%03h]", i), mem_i.mem[i], shadow[i]);
    end
  endtask

  task automatic runEntry(input int n);
    testEntry e;
    int       errorsBefore;
    int       rd0;
    int       wr0;
    string    verdict;
    e = ops[n];
    stepCycle();
    errorsBefore = errors;
    rd0 = readBeats;
    wr0 = writeBeats;
    if (e.kind == OpFlush) begin
      flushReq = 1'b1;
      stepCycle();
      flushReq = 1'b0;
      while (!flushDone) begin
        stepCycle();
      end
      compareBacking();
    end else begin
      req.write    = (e.kind == OpWrite);
      req.addr     = e.addr;
      req.byteMask = e.mask;
      req.wdata    = e.wdata;
      reqValid     = 1'b1;
      stepCycle();
      while (!respValid) begin
        stepCycle();
      end
      if (e.kind == OpWrite) begin
        shadow[e.addr[13:2]] = mergeBytes(shadow[e.addr[13:2]], e.wdata, e.mask);
      end else begin
        checkWord("rdata", rdata, shadow[e.addr[13:2]]);
      end
      reqValid = 1'b0;
    end
    checkCount("readBeats", readBeats - rd0, e.expRd);
    checkCount("writeBeats", writeBeats - wr0, e.expWr);
    if (errors == errorsBefore) begin
      verdict = "ok";
      passedTests++;
    end else begin
      verdict = "FAILED";
    end
    $display("test %0d %s 0x%08h %s", n, e.kind.name(), e.addr, verdict);
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    reqValid    = 1'b0;
    flushReq    = 1'b0;
    req         = '0;
    errors      = 0;
    passedTests = 0;
    cycles      = 0;
    cycleLimit  = 0;
    for (int i = 0; i < MemWords; i++) begin
      shadow[i] = fillWord(i);
    end
    buildOps();
    cycleLimit = ops.size() * CyclesPerEntry;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int n = 0; n < ops.size(); n++) begin
      runEntry(n);
    end
    $display("Summary: %0d of %0d tests ok, %0d errors", passedTests, ops.size(), errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
